/* verilog/llc_macros.svh */
/* Cache geometry for the LLC controller. Included by the package, the RTL and the
   testbench wherever sizes are needed. */

`ifndef LLC_MACROS_SVH
`define LLC_MACROS_SVH

// 4-way, 16 sets, 4 words per line
`define LLC_WAYS            4
`define LLC_SETS            16
`define LLC_WORDS_PER_LINE  4

// word address width
`define LLC_ADDR_BITS       12

`define LLC_WORD_BITS       32
`define LLC_WAY_BITS        2
`define LLC_SET_BITS        4
`define LLC_OFFSET_BITS     2

// tag is what is left of the word address
`define LLC_TAG_BITS        (`LLC_ADDR_BITS - `LLC_SET_BITS - `LLC_OFFSET_BITS)
`define LLC_LINE_ADDR_BITS  (`LLC_ADDR_BITS - `LLC_OFFSET_BITS)

`endif

/* verilog/llc_pkg.sv */
/* Shared types of the LLC controller: FSM states, opcodes and address fields.
   Imported by the RTL modules and the testbench. */

`include "llc_macros.svh"

package llc_pkg;

    // controller FSM, one request at a time
    typedef enum logic [2:0] {
        DECODE,
        READ_SET,
        READ_MEM,
        LOOKUP,
        PROCESS,
        UPDATE
    } llc_state_t;

    // requester side
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } llc_op_t;

    // memory side, whole lines only
    typedef enum logic {
        MEM_READ_LINE,
        MEM_WRITE_LINE
    } mem_op_t;

    typedef logic [`LLC_ADDR_BITS-1:0]      addr_t;
    typedef logic [`LLC_LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`LLC_TAG_BITS-1:0]       llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0]       llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0]       llc_way_t;

    typedef logic [`LLC_WORD_BITS-1:0]      word_t;
    // word 0 sits in the low bits
    typedef word_t [`LLC_WORDS_PER_LINE-1:0] line_t;

endpackage

/* verilog/llc_store_if.sv */
/* Port bundle of the local tag/state/line arrays. The core drives it through ctrl,
   llc_localmem serves it through mem. */

`timescale 1ns/1ns
`include "llc_macros.svh"

interface llc_store_if;
    import llc_pkg::*;

    // read request, whole set
    logic rd_en;
    llc_set_t set;

    // write of a single way
    logic wr_en;
    llc_way_t way;
    llc_tag_t wr_tag;
    logic wr_valid;
    logic wr_dirty;
    line_t wr_line;

    // bump the set's round-robin pointer
    logic evict_adv;

    // read-out, valid the cycle after rd_en
    llc_tag_t [`LLC_WAYS-1:0] rd_tag;
    logic [`LLC_WAYS-1:0] rd_valid;
    logic [`LLC_WAYS-1:0] rd_dirty;
    line_t [`LLC_WAYS-1:0] rd_line;
    llc_way_t rd_evict_way;

    modport ctrl (
        output rd_en, set, wr_en, way, wr_tag, wr_valid, wr_dirty, wr_line,
        output evict_adv,
        input  rd_tag, rd_valid, rd_dirty, rd_line, rd_evict_way
    );

    modport mem (
        input  rd_en, set, wr_en, way, wr_tag, wr_valid, wr_dirty, wr_line,
        input  evict_adv,
        output rd_tag, rd_valid, rd_dirty, rd_line, rd_evict_way
    );

endinterface

/* verilog/llc_input_decoder.sv */
/* Request register of the LLC core. Captures a request on its handshake and holds
   it, split into tag, set and offset, until the next one is accepted. */

`timescale 1ns/1ns
`include "llc_macros.svh"

module llc_input_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  logic                        ready_i,
    input  llc_pkg::llc_op_t            op_i,
    input  llc_pkg::addr_t              addr_i,
    input  llc_pkg::word_t              wdata_i,
    output llc_pkg::llc_op_t            op_o,
    output llc_pkg::llc_tag_t           tag_o,
    output llc_pkg::llc_set_t           set_o,
    output logic [`LLC_OFFSET_BITS-1:0] offset_o,
    output llc_pkg::word_t              wdata_o
);
    import llc_pkg::*;

    addr_t addr_q;
    logic take;

    assign take = valid_i & ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_o <= OP_READ;
            addr_q <= '0;
        end else if (take) begin
            op_o <= op_i;
            addr_q <= addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wdata_o <= wdata_i;
        end
    end

    // address layout is {tag, set, offset}
    assign offset_o = addr_q[`LLC_OFFSET_BITS-1:0];
    assign set_o = addr_q[`LLC_OFFSET_BITS +: `LLC_SET_BITS];
    assign tag_o = addr_q[`LLC_ADDR_BITS-1 -: `LLC_TAG_BITS];

endmodule

/* verilog/llc_localmem.sv */
/* Local arrays of the LLC: per-way tags, valid and dirty bits and line data, plus
   one round-robin eviction pointer per set. Reads return a whole set a cycle later. */

`timescale 1ns/1ns
`include "llc_macros.svh"

module llc_localmem (
    input  logic  clk,
    input  logic  rst,
    llc_store_if.mem store
);
    import llc_pkg::*;

    llc_tag_t tag_mem   [`LLC_WAYS][`LLC_SETS];
    logic     valid_mem [`LLC_WAYS][`LLC_SETS];
    logic     dirty_mem [`LLC_WAYS][`LLC_SETS];
    line_t    line_mem  [`LLC_WAYS][`LLC_SETS];
    llc_way_t evict_ptr [`LLC_SETS];

    // state arrays and their read-out
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                for (int s = 0; s < `LLC_SETS; s++) begin
                    tag_mem[w][s] <= '0;
                    valid_mem[w][s] <= 1'b0;
                    dirty_mem[w][s] <= 1'b0;
                end
            end
            for (int s = 0; s < `LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
            end
            store.rd_tag <= '0;
            store.rd_valid <= '0;
            store.rd_dirty <= '0;
            store.rd_evict_way <= '0;
        end else begin
            if (store.wr_en) begin
                tag_mem[store.way][store.set] <= store.wr_tag;
                valid_mem[store.way][store.set] <= store.wr_valid;
                dirty_mem[store.way][store.set] <= store.wr_dirty;
            end
            // 2-bit pointer wraps on its own
            if (store.evict_adv) begin
                evict_ptr[store.set] <= evict_ptr[store.set] + 1'b1;
            end
            if (store.rd_en) begin
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    store.rd_tag[w] <= tag_mem[w][store.set];
                    store.rd_valid[w] <= valid_mem[w][store.set];
                    store.rd_dirty[w] <= dirty_mem[w][store.set];
                end
                store.rd_evict_way <= evict_ptr[store.set];
            end
        end
    end

    // line data
    always_ff @(posedge clk) begin
        if (store.wr_en) begin
            line_mem[store.way][store.set] <= store.wr_line;
        end
        if (store.rd_en) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                store.rd_line[w] <= line_mem[w][store.set];
            end
        end
    end

endmodule

/* verilog/llc_lookup_way.sv */
/* Tag compare and victim choice. Buffers the set read from the local arrays and
   reports the hit way and the victim for a miss, with the victim's dirty state. */

`timescale 1ns/1ns
`include "llc_macros.svh"

module llc_lookup_way (
    input  logic               clk,
    input  logic               rst,
    llc_store_if.ctrl          store,
    input  llc_pkg::llc_tag_t  tag_i,
    output logic               hit_o,
    output llc_pkg::llc_way_t  hit_way_o,
    output llc_pkg::llc_way_t  victim_way_o,
    output logic               victim_dirty_o,
    output llc_pkg::llc_tag_t  victim_tag_o,
    output llc_pkg::line_t     victim_line_o
);
    import llc_pkg::*;

    logic rd_q;
    llc_tag_t [`LLC_WAYS-1:0] tags_buf;
    logic [`LLC_WAYS-1:0] valid_buf;
    logic [`LLC_WAYS-1:0] dirty_buf;
    line_t [`LLC_WAYS-1:0] lines_buf;
    llc_way_t evict_way_buf;

    // rd_q marks the cycle with fresh read-out data
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_q <= 1'b0;
            tags_buf <= '0;
            valid_buf <= '0;
            dirty_buf <= '0;
            evict_way_buf <= '0;
        end else begin
            rd_q <= store.rd_en;
            if (rd_q) begin
                tags_buf <= store.rd_tag;
                valid_buf <= store.rd_valid;
                dirty_buf <= store.rd_dirty;
                evict_way_buf <= store.rd_evict_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_q) begin
            lines_buf <= store.rd_line;
        end
    end

    // scanning downwards leaves the lowest matching way
    always_comb begin
        hit_o = 1'b0;
        hit_way_o = '0;
        victim_way_o = evict_way_buf;
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            if (valid_buf[w] && tags_buf[w] == tag_i) begin
                hit_o = 1'b1;
                hit_way_o = llc_way_t'(w);
            end
            if (!valid_buf[w]) begin
                victim_way_o = llc_way_t'(w);
            end
        end
    end

    assign victim_dirty_o = valid_buf[victim_way_o] & dirty_buf[victim_way_o];
    assign victim_tag_o = tags_buf[victim_way_o];
    assign victim_line_o = lines_buf[victim_way_o];

endmodule

/* verilog/llc_core.sv */
/* Last-level cache controller, write-back and write-allocate, one request in flight.
   Top level of the RTL: requester port, memory port and the staged FSM. */

`timescale 1ns/1ns
`include "llc_macros.svh"

module llc_core (
    input  logic                 clk,
    input  logic                 rst,
    // requester
    input  logic                 req_valid_i,
    input  llc_pkg::llc_op_t     req_op_i,
    input  llc_pkg::addr_t       req_addr_i,
    input  llc_pkg::word_t       req_wdata_i,
    output logic                 req_ready_o,
    output logic                 rsp_valid_o,
    output llc_pkg::word_t       rsp_data_o,
    input  logic                 rsp_ready_i,
    // main memory
    output logic                 mem_req_valid_o,
    output llc_pkg::mem_op_t     mem_req_op_o,
    output llc_pkg::line_addr_t  mem_req_addr_o,
    output llc_pkg::line_t       mem_req_line_o,
    input  logic                 mem_req_ready_i,
    input  logic                 mem_rsp_valid_i,
    input  llc_pkg::line_t       mem_rsp_line_i,
    output logic                 mem_rsp_ready_o
);
    import llc_pkg::*;

    llc_state_t state, next_state;

    llc_op_t dec_op;
    llc_tag_t dec_tag;
    llc_set_t dec_set;
    logic [`LLC_OFFSET_BITS-1:0] dec_offset;
    word_t dec_wdata;

    logic hit;
    llc_way_t hit_way;
    llc_way_t victim_way;
    logic victim_dirty;
    llc_tag_t victim_tag;
    line_t victim_line;

    logic wb_sent, rd_sent, upd_done;
    logic need_wb, wb_phase, miss_active;
    logic mem_req_fire, mem_rsp_fire, process_done;
    line_t fill_line;
    line_t base_line;
    line_t upd_line;

    llc_store_if store ();

    llc_input_decoder i_input_decoder (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (req_valid_i),
        .ready_i  (req_ready_o),
        .op_i     (req_op_i),
        .addr_i   (req_addr_i),
        .wdata_i  (req_wdata_i),
        .op_o     (dec_op),
        .tag_o    (dec_tag),
        .set_o    (dec_set),
        .offset_o (dec_offset),
        .wdata_o  (dec_wdata)
    );

    llc_localmem i_localmem (
        .clk   (clk),
        .rst   (rst),
        .store (store.mem)
    );

    llc_lookup_way i_lookup_way (
        .clk            (clk),
        .rst            (rst),
        .store          (store.ctrl),
        .tag_i          (dec_tag),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_line_o  (victim_line)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DECODE: begin
                if (req_valid_i) begin
                    next_state = READ_SET;
                end
            end
            READ_SET: next_state = READ_MEM;
            READ_MEM: next_state = LOOKUP;
            LOOKUP: next_state = PROCESS;
            PROCESS: begin
                if (process_done) begin
                    next_state = UPDATE;
                end
            end
            UPDATE: begin
                if (rsp_ready_i) begin
                    next_state = DECODE;
                end
            end
            default: next_state = DECODE;
        endcase
    end

    assign req_ready_o = (state == DECODE);

    // miss sequencing: write-back, then line read, then wait for the line
    assign miss_active = (state == PROCESS) && !hit;
    assign need_wb = victim_dirty;
    assign wb_phase = need_wb && !wb_sent;

    assign mem_req_valid_o = miss_active && (wb_phase || !rd_sent);
    assign mem_req_op_o = wb_phase ? MEM_WRITE_LINE : MEM_READ_LINE;
    assign mem_req_addr_o = wb_phase ? {victim_tag, dec_set} : {dec_tag, dec_set};
    assign mem_req_line_o = victim_line;
    assign mem_rsp_ready_o = miss_active && rd_sent;

    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;
    assign process_done = hit || mem_rsp_fire;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_sent <= 1'b0;
            rd_sent <= 1'b0;
            upd_done <= 1'b0;
        end else if (state == DECODE) begin
            wb_sent <= 1'b0;
            rd_sent <= 1'b0;
            upd_done <= 1'b0;
        end else begin
            if (mem_req_fire) begin
                if (wb_phase) begin
                    wb_sent <= 1'b1;
                end else begin
                    rd_sent <= 1'b1;
                end
            end
            if (store.wr_en) begin
                upd_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_fire) begin
            fill_line <= mem_rsp_line_i;
        end
    end

    // read-out regs hold the set until the next request, so the hit line is still there
    assign base_line = hit ? store.rd_line[hit_way] : fill_line;

    always_comb begin
        upd_line = base_line;
        if (dec_op == OP_WRITE) begin
            upd_line[dec_offset] = dec_wdata;
        end
    end

    // array access
    assign store.rd_en = (state == READ_MEM);
    assign store.set = dec_set;
    assign store.wr_en = (state == UPDATE) && !upd_done;
    assign store.way = hit ? hit_way : victim_way;
    assign store.wr_tag = dec_tag;
    assign store.wr_valid = 1'b1;
    // a refill comes in clean, a hit keeps what it had
    assign store.wr_dirty = (dec_op == OP_WRITE) || (hit && store.rd_dirty[hit_way]);
    assign store.wr_line = upd_line;
    assign store.evict_adv = store.wr_en && !hit;

    // response, the addressed word after the merge
    assign rsp_valid_o = (state == UPDATE);
    assign rsp_data_o = upd_line[dec_offset];

endmodule

/* bench/llc_ref_model.svh */
/* Reference model of the LLC and of main memory, included into the testbench module.
   Predicts each response and the memory requests that an access must cause. */

`ifndef LLC_REF_MODEL_SVH
`define LLC_REF_MODEL_SVH

word_t    main_mem [1 << `LLC_ADDR_BITS];
logic     m_valid  [`LLC_WAYS][`LLC_SETS];
logic     m_dirty  [`LLC_WAYS][`LLC_SETS];
llc_tag_t m_tag    [`LLC_WAYS][`LLC_SETS];
line_t    m_line   [`LLC_WAYS][`LLC_SETS];
llc_way_t m_ptr    [`LLC_SETS];

// memory requests still owed by the DUT for the current access, oldest first
mem_op_t    exp_op_q[$];
line_addr_t exp_addr_q[$];
line_t      exp_line_q[$];

// fill pattern, every address bit shows up twice
function automatic word_t initial_word(addr_t a);
    return {4'ha, a, 4'h5, ~a};
endfunction

function automatic line_t mem_line(line_addr_t la);
    line_t l;
    for (int i = 0; i < `LLC_WORDS_PER_LINE; i++) begin
        l[i] = main_mem[{la, i[`LLC_OFFSET_BITS-1:0]}];
    end
    return l;
endfunction

task automatic model_reset();
    for (int a = 0; a < (1 << `LLC_ADDR_BITS); a++) begin
        main_mem[a] = initial_word(addr_t'(a));
    end
    for (int s = 0; s < `LLC_SETS; s++) begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
            m_tag[w][s] = '0;
        end
        m_ptr[s] = '0;
    end
endtask

// victim is the lowest invalid way, else the set pointer; pointer moves on every miss
task automatic model_access(input llc_op_t op, input addr_t addr, input word_t wdata,
                            output word_t rsp, output logic hit);
    llc_tag_t tag;
    llc_set_t s;
    logic [`LLC_OFFSET_BITS-1:0] off;
    llc_way_t way;
    logic free;
    line_addr_t la;
    tag = addr[`LLC_ADDR_BITS-1 -: `LLC_TAG_BITS];
    s = addr[`LLC_OFFSET_BITS +: `LLC_SET_BITS];
    off = addr[`LLC_OFFSET_BITS-1:0];
    hit = 1'b0;
    free = 1'b0;
    way = m_ptr[s];
    for (int w = 0; w < `LLC_WAYS; w++) begin
        if (!hit && m_valid[w][s] && m_tag[w][s] == tag) begin
            hit = 1'b1;
            way = llc_way_t'(w);
        end
    end
    if (!hit) begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (!free && !m_valid[w][s]) begin
                free = 1'b1;
                way = llc_way_t'(w);
            end
        end
        // write-back goes out before the refill
        if (m_valid[way][s] && m_dirty[way][s]) begin
            la = {m_tag[way][s], s};
            exp_op_q.push_back(MEM_WRITE_LINE);
            exp_addr_q.push_back(la);
            exp_line_q.push_back(m_line[way][s]);
            for (int i = 0; i < `LLC_WORDS_PER_LINE; i++) begin
                main_mem[{la, i[`LLC_OFFSET_BITS-1:0]}] = m_line[way][s][i];
            end
        end
        exp_op_q.push_back(MEM_READ_LINE);
        exp_addr_q.push_back({tag, s});
        exp_line_q.push_back('0);
        m_line[way][s] = mem_line({tag, s});
        m_tag[way][s] = tag;
        m_valid[way][s] = 1'b1;
        m_dirty[way][s] = 1'b0;
        m_ptr[s] = m_ptr[s] + 1'b1;
    end
    if (op == OP_WRITE) begin
        m_line[way][s][off] = wdata;
        m_dirty[way][s] = 1'b1;
    end
    rsp = m_line[way][s][off];
endtask

`endif

/* bench/tb_llc.sv */
/* Testbench of the LLC core. Random reads and writes over a few sets against a main
   memory with random back-pressure; responses and memory requests checked against a model. */

`timescale 1ns/1ns
`include "llc_macros.svh"

module tb_llc;
    import llc_pkg::*;

    localparam int NUM_REQS = 400;
    localparam int ACCEPT_TIMEOUT = 50;
    localparam int RSP_TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       req_valid_i;
    llc_op_t    req_op_i;
    addr_t      req_addr_i;
    word_t      req_wdata_i;
    logic       req_ready_o;
    logic       rsp_valid_o;
    word_t      rsp_data_o;
    logic       rsp_ready_i;
    logic       mem_req_valid_o;
    mem_op_t    mem_req_op_o;
    line_addr_t mem_req_addr_o;
    line_t      mem_req_line_o;
    logic       mem_req_ready_i;
    logic       mem_rsp_valid_i;
    line_t      mem_rsp_line_i;
    logic       mem_rsp_ready_o;

    int hits;
    int misses;
    int wbacks;
    // memory responder state
    logic mem_rd_pending;
    line_addr_t mem_rd_addr;
    logic mrsp_taken;

    `include "llc_ref_model.svh"

    llc_core i_llc_core (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_data_o      (rsp_data_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_op_o    (mem_req_op_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_line_i  (mem_rsp_line_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic value_error(input string msg);
        fail_now($sformatf("** Error at %0t ns: %s", $time, msg));
    endtask

    task automatic check_rsp(input word_t exp);
        if (rsp_data_o !== exp) begin
            value_error($sformatf("rsp_data_o %08h, expected %08h", rsp_data_o, exp));
        end
    endtask

    // line data only matters for a write-back
    task automatic check_mem_req(input mem_op_t op, input line_addr_t la, input line_t line);
        if (mem_req_op_o !== op || mem_req_addr_o !== la) begin
            value_error($sformatf("memory request %s @%03h, expected %s @%03h",
                mem_req_op_o.name(), mem_req_addr_o, op.name(), la));
        end
        if (op == MEM_WRITE_LINE && mem_req_line_o !== line) begin
            value_error($sformatf("write-back line %032h, expected %032h",
                mem_req_line_o, line));
        end
    endtask

    task automatic check_idle_outputs();
        if (rsp_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0 || mem_rsp_ready_o !== 1'b0) begin
            value_error("valid or ready output high while idle after reset");
        end
    endtask

    // few sets, seven tags each, so the 4 ways overflow
    function automatic addr_t pick_addr();
        int unsigned r;
        llc_tag_t tag;
        llc_set_t set_idx;
        logic [`LLC_OFFSET_BITS-1:0] off;
        r = $urandom_range(0, 6) * 9;
        tag = r[`LLC_TAG_BITS-1:0];
        case ($urandom_range(0, 2))
            0: set_idx = 4'd0;
            1: set_idx = 4'd7;
            default: set_idx = 4'd13;
        endcase
        r = $urandom_range(0, 3);
        off = r[`LLC_OFFSET_BITS-1:0];
        return {tag, set_idx, off};
    endfunction

    task automatic drive_back_pressure();
        rsp_ready_i = ($urandom_range(0, 3) != 0);
        mem_req_ready_i = ($urandom_range(0, 1) != 0);
        if (mrsp_taken) begin
            mem_rsp_valid_i = 1'b0;
            mrsp_taken = 1'b0;
        end
        if (mem_rd_pending && !mem_rsp_valid_i && $urandom_range(0, 1) == 1) begin
            mem_rsp_valid_i = 1'b1;
            mem_rsp_line_i = mem_line(mem_rd_addr);
        end
    endtask

    // outputs are sampled on the falling edge, handshakes resolve on the next rising edge
    task automatic run_request(input llc_op_t op, input addr_t addr, input word_t wdata);
        word_t exp_rsp;
        word_t held_data;
        logic hit;
        logic done;
        logic mreq_wait;
        logic rsp_wait;
        mem_op_t held_op;
        line_addr_t held_addr;
        line_t held_line;
        int cycles;
        model_access(op, addr, wdata, exp_rsp, hit);
        if (hit) begin
            hits++;
        end else begin
            misses++;
        end
        repeat ($urandom_range(0, 2)) @(negedge clk);
        req_valid_i = 1'b1;
        req_op_i = op;
        req_addr_i = addr;
        req_wdata_i = wdata;
        cycles = 0;
        while (!req_ready_o) begin
            cycles++;
            if (cycles > ACCEPT_TIMEOUT) begin
                fail_now("timeout: the request was never accepted");
            end
            @(negedge clk);
        end
        @(negedge clk);
        req_valid_i = 1'b0;

        done = 1'b0;
        mreq_wait = 1'b0;
        rsp_wait = 1'b0;
        cycles = 0;
        while (!done) begin
            if (mreq_wait) begin
                if (!mem_req_valid_o) begin
                    value_error("mem_req_valid_o dropped before mem_req_ready_i");
                end
                check_mem_req(held_op, held_addr, held_line);
            end
            if (rsp_wait) begin
                if (!rsp_valid_o) begin
                    value_error("rsp_valid_o dropped before rsp_ready_i");
                end
                check_rsp(held_data);
            end
            drive_back_pressure();
            if (mem_req_valid_o && exp_op_q.size() == 0) begin
                value_error("memory request where none was expected");
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                check_mem_req(exp_op_q[0], exp_addr_q[0], exp_line_q[0]);
                void'(exp_op_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(exp_line_q.pop_front());
                if (mem_req_op_o == MEM_READ_LINE) begin
                    mem_rd_pending = 1'b1;
                    mem_rd_addr = mem_req_addr_o;
                end else begin
                    wbacks++;
                end
            end
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                mrsp_taken = 1'b1;
                mem_rd_pending = 1'b0;
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_op_q.size() != 0) begin
                    value_error("response before the expected memory requests");
                end
                check_rsp(exp_rsp);
                done = 1'b1;
            end
            mreq_wait = mem_req_valid_o && !mem_req_ready_i;
            held_op = mem_req_op_o;
            held_addr = mem_req_addr_o;
            held_line = mem_req_line_o;
            rsp_wait = rsp_valid_o && !rsp_ready_i;
            held_data = rsp_data_o;
            cycles++;
            if (cycles > RSP_TIMEOUT) begin
                fail_now("timeout: no response to the accepted request");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        llc_op_t op;
        addr_t addr;
        word_t wdata;
        void'($urandom(71));
        rst = 1'b0;
        req_valid_i = 1'b0;
        req_op_i = OP_READ;
        req_addr_i = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_line_i = '0;
        hits = 0;
        misses = 0;
        wbacks = 0;
        mem_rd_pending = 1'b0;
        mem_rd_addr = '0;
        mrsp_taken = 1'b0;
        model_reset();

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        rst = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        for (int n = 0; n < NUM_REQS; n++) begin
            op = ($urandom_range(0, 1) == 1) ? OP_WRITE : OP_READ;
            addr = pick_addr();
            wdata = $urandom;
            run_request(op, addr, wdata);
        end

        $display("%0d requests: %0d hits, %0d misses, %0d write-backs",
            NUM_REQS, hits, misses, wbacks);
        $display("TEST OK");
        $finish;
    end

endmodule

/* project.f */
+incdir+verilog
+incdir+bench
verilog/llc_pkg.sv
verilog/llc_store_if.sv
verilog/llc_input_decoder.sv
verilog/llc_localmem.sv
verilog/llc_lookup_way.sv
verilog/llc_core.sv
bench/tb_llc.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing
TOP       = tb_llc
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the pass line decides the status, the simulator's exit code is not trusted alone
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
